// File: common/tile_cfg.svh
/*
 * Tile configuration macros: data cache port widths, walker command
 * codes, L2 fill beat geometry and fixed acquire fields
 */
`ifndef TILE_CFG_SVH
`define TILE_CFG_SVH

// Data cache port widths
`define TILE_PADDR_W            40
`define TILE_DATA_W             64
`define TILE_BE_W               8
`define TILE_SIZE_W             3

// Page walker command encoding
`define TILE_PTW_CMD_W          5
`define TILE_PTW_CMD_AMO_OR     5'b01010

// L2 instruction fill
`define TILE_FILL_BEAT_W        128
`define TILE_FILL_BEATS         4

// Fixed acquire message fields
`define TILE_ACQ_A_TYPE_W       3
`define TILE_ACQ_A_TYPE         3'b001
`define TILE_ACQ_UNION_W        17
`define TILE_ACQ_UNION          17'h001C1

`endif

// File: common/dmem_pkg.sv
/*
 * Data cache port types: walker request/response, shared cache
 * request/response and the core response
 */
`include "tile_cfg.svh"

package dmem_pkg;

    // Cache operation
    typedef enum logic [1:0] {
        DMEM_LOAD   = 2'd0,
        DMEM_AMO_OR = 2'd1
    } dmem_op_e;

    typedef logic dmem_sid_t;

    // Source ids on the shared port
    localparam dmem_sid_t SID_PTW  = 1'b0;
    localparam dmem_sid_t SID_CORE = 1'b1;

    // Page walker side
    typedef struct packed {
        logic [`TILE_PTW_CMD_W-1:0] cmd;
        logic [`TILE_PADDR_W-1:0]   addr;
        logic [`TILE_DATA_W-1:0]    data;
        logic [`TILE_SIZE_W-1:0]    size;
    } ptw_req_t;

    typedef struct packed {
        logic                    valid;
        logic [`TILE_DATA_W-1:0] data;
    } ptw_resp_t;

    //----------------------------------------------------------------------
    // Shared data cache port
    //----------------------------------------------------------------------
    typedef struct packed {
        logic [`TILE_PADDR_W-1:0] addr;
        logic [`TILE_DATA_W-1:0]  wdata;
        dmem_op_e                 op;
        logic [`TILE_BE_W-1:0]    be;
        logic [`TILE_SIZE_W-1:0]  size;
        dmem_sid_t                sid;
    } dmem_req_t;

    typedef struct packed {
        logic [`TILE_DATA_W-1:0] rdata;
        dmem_sid_t               sid;
    } dmem_rsp_t;

    // Back toward the load/store unit
    typedef struct packed {
        logic                    valid;
        logic [`TILE_DATA_W-1:0] rdata;
    } dmem_core_rsp_t;

endpackage

// File: common/ifill_pkg.sv
/*
 * L2 network types for instruction fills: acquire, grant beat and
 * the assembled cache line
 */
`include "tile_cfg.svh"

package ifill_pkg;

    localparam int unsigned FILL_BEAT_IDX_W = $clog2(`TILE_FILL_BEATS);

    // Index of the beat that completes a line
    localparam logic [FILL_BEAT_IDX_W-1:0] FILL_LAST_BEAT =
        FILL_BEAT_IDX_W'(`TILE_FILL_BEATS - 1);

    //----------------------------------------------------------------------
    // Acquire toward L2
    //----------------------------------------------------------------------
    typedef struct packed {
        logic [`TILE_PADDR_W-1:0]     addr_block;
        logic [`TILE_ACQ_A_TYPE_W-1:0] a_type;
        logic [`TILE_ACQ_UNION_W-1:0]  union_bits;
        logic                          is_builtin_type;
        logic [FILL_BEAT_IDX_W-1:0]    addr_beat;
        logic                          client_xact_id;
    } l2_acquire_t;

    // One grant beat from L2
    typedef struct packed {
        logic [FILL_BEAT_IDX_W-1:0]  addr_beat;
        logic [`TILE_FILL_BEAT_W-1:0] data;
    } l2_grant_t;

    // Line handed back to the fetch side, beat 0 in the low bits
    typedef struct packed {
        logic [`TILE_PADDR_W-1:0]                          paddr;
        logic [`TILE_FILL_BEATS-1:0][`TILE_FILL_BEAT_W-1:0] data;
    } fill_line_t;

endpackage

// File: dmem_port/ptw_dmem_adapter.sv
/*
 * Page walker to data cache request translation with a single
 * outstanding walk
 */
`timescale 1ns/1ps
`include "tile_cfg.svh"

module ptw_dmem_adapter (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    ptw_req_valid_i,
    input  dmem_pkg::ptw_req_t      ptw_req_i,
    output logic                    ptw_req_ready_o,
    output dmem_pkg::ptw_resp_t     ptw_resp_o,
    output logic                    req_valid_o,
    output dmem_pkg::dmem_req_t     req_o,
    input  logic                    req_ready_i,
    input  logic                    rsp_valid_i,
    input  logic [`TILE_DATA_W-1:0] rsp_data_i
);
    import dmem_pkg::*;

    logic outstanding_q;
    logic is_amo_or;
    logic req_fire;

    // Only the atomic OR writes, all other walker commands read
    assign is_amo_or = (ptw_req_i.cmd == `TILE_PTW_CMD_AMO_OR);

    always_comb begin
        req_o.addr  = ptw_req_i.addr;
        req_o.wdata = ptw_req_i.data;
        req_o.op    = is_amo_or ? DMEM_AMO_OR : DMEM_LOAD;
        req_o.be    = is_amo_or ? '1 : '0;
        req_o.size  = ptw_req_i.size;
        req_o.sid   = SID_PTW;
    end

    // One walk in flight at a time
    assign req_valid_o     = ptw_req_valid_i && !outstanding_q;
    assign ptw_req_ready_o = req_ready_i && !outstanding_q;
    assign req_fire        = req_valid_o && req_ready_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            outstanding_q <= 1'b0;
        end else if (req_fire) begin
            outstanding_q <= 1'b1;
        end else if (rsp_valid_i) begin
            outstanding_q <= 1'b0;
        end
    end

    assign ptw_resp_o.valid = rsp_valid_i;
    assign ptw_resp_o.data  = rsp_data_i;

    // Cache answers only walks that went out through the arbiter
    a_rsp_needs_walk: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        rsp_valid_i |-> outstanding_q
    ) else $error("walker response with no walk outstanding");

endmodule

// File: dmem_port/dmem_arbiter.sv
/*
 * Walker/core arbiter for the data cache port, registered output
 * stage and sid based response routing
 */
`timescale 1ns/1ps
`include "tile_cfg.svh"

module dmem_arbiter (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     ptw_valid_i,
    input  dmem_pkg::dmem_req_t      ptw_req_i,
    output logic                     ptw_ready_o,
    input  logic                     core_valid_i,
    input  dmem_pkg::dmem_req_t      core_req_i,
    output logic                     core_ready_o,
    output logic                     dcache_valid_o,
    output dmem_pkg::dmem_req_t      dcache_req_o,
    input  logic                     dcache_ready_i,
    input  logic                     dcache_rsp_valid_i,
    input  dmem_pkg::dmem_rsp_t      dcache_rsp_i,
    output logic                     ptw_rsp_valid_o,
    output logic [`TILE_DATA_W-1:0]  ptw_rsp_data_o,
    output dmem_pkg::dmem_core_rsp_t core_rsp_o
);
    import dmem_pkg::*;

    logic      out_valid_q;
    dmem_req_t out_req_q;
    logic      out_free;
    logic      any_valid;
    dmem_req_t winner;

    //----------------------------------------------------------------------
    // Request side
    //----------------------------------------------------------------------

    // Register can take a new entry when empty or emptying now
    assign out_free  = !out_valid_q || dcache_ready_i;
    assign any_valid = ptw_valid_i || core_valid_i;

    // Walker has fixed priority
    assign ptw_ready_o  = out_free;
    assign core_ready_o = out_free && !ptw_valid_i;

    always_comb begin
        if (ptw_valid_i) begin
            winner     = ptw_req_i;
            winner.sid = SID_PTW;
        end else begin
            winner     = core_req_i;
            winner.sid = SID_CORE;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            out_valid_q <= 1'b0;
        end else if (out_free) begin
            out_valid_q <= any_valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (out_free && any_valid) begin
            out_req_q <= winner;
        end
    end

    assign dcache_valid_o = out_valid_q;
    assign dcache_req_o   = out_req_q;

    //----------------------------------------------------------------------
    // Response side
    //----------------------------------------------------------------------
    assign ptw_rsp_valid_o  = dcache_rsp_valid_i && (dcache_rsp_i.sid == SID_PTW);
    assign ptw_rsp_data_o   = dcache_rsp_i.rdata;
    assign core_rsp_o.valid = dcache_rsp_valid_i && (dcache_rsp_i.sid == SID_CORE);
    assign core_rsp_o.rdata = dcache_rsp_i.rdata;

    // Held request must not change under back-pressure
    a_req_stable: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        dcache_valid_o && !dcache_ready_i |=> dcache_valid_o && $stable(dcache_req_o)
    ) else $error("cache request changed while stalled");

    // An unknown sid would drop the response on the floor
    a_rsp_sid_known: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        dcache_rsp_valid_i |-> !$isunknown(dcache_rsp_i.sid)
    ) else $error("cache response with unknown sid");

endmodule

// File: ifill/l2_fill_adapter.sv
/*
 * Instruction fill to L2 adapter: acquire issue and assembly of the
 * grant beats into one line
 */
`timescale 1ns/1ps
`include "tile_cfg.svh"

module l2_fill_adapter (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     fill_req_valid_i,
    input  logic [`TILE_PADDR_W-1:0] fill_paddr_i,
    output logic                     fill_req_ready_o,
    output logic                     l2_acquire_valid_o,
    output ifill_pkg::l2_acquire_t   l2_acquire_o,
    input  logic                     l2_acquire_ready_i,
    input  logic                     l2_grant_valid_i,
    input  ifill_pkg::l2_grant_t     l2_grant_i,
    output logic                     fill_line_valid_o,
    output ifill_pkg::fill_line_t    fill_line_o
);
    import ifill_pkg::*;

    typedef enum logic [1:0] {
        FILL_IDLE,
        FILL_ACQ,
        FILL_COLLECT
    } fill_state_e;

    fill_state_e                                        state_q;
    fill_state_e                                        state_d;
    logic [`TILE_PADDR_W-1:0]                           line_addr_q;
    logic [`TILE_FILL_BEATS-1:0][`TILE_FILL_BEAT_W-1:0] beats_q;
    logic                                               line_valid_q;
    logic                                               req_fire;
    logic                                               grant_take;
    logic                                               last_beat;

    assign fill_req_ready_o = (state_q == FILL_IDLE);
    assign req_fire         = fill_req_valid_i && fill_req_ready_o;
    assign grant_take       = l2_grant_valid_i && (state_q == FILL_COLLECT);
    assign last_beat        = (l2_grant_i.addr_beat == FILL_LAST_BEAT);

    //----------------------------------------------------------------------
    // Controller
    //----------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            FILL_IDLE: begin
                if (req_fire) begin
                    state_d = FILL_ACQ;
                end
            end
            FILL_ACQ: begin
                if (l2_acquire_ready_i) begin
                    state_d = FILL_COLLECT;
                end
            end
            FILL_COLLECT: begin
                if (grant_take && last_beat) begin
                    state_d = FILL_IDLE;
                end
            end
            default: begin
                state_d = FILL_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q      <= FILL_IDLE;
            line_valid_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            line_valid_q <= grant_take && last_beat;
        end
    end

    // Line address and beat buffer
    always_ff @(posedge clk_i) begin
        if (req_fire) begin
            line_addr_q <= fill_paddr_i;
        end
        if (grant_take) begin
            beats_q[l2_grant_i.addr_beat] <= l2_grant_i.data;
        end
    end

    // Fixed acquire fields, whole line as a builtin get
    assign l2_acquire_valid_o           = (state_q == FILL_ACQ);
    assign l2_acquire_o.addr_block      = line_addr_q;
    assign l2_acquire_o.a_type          = `TILE_ACQ_A_TYPE;
    assign l2_acquire_o.union_bits      = `TILE_ACQ_UNION;
    assign l2_acquire_o.is_builtin_type = 1'b1;
    assign l2_acquire_o.addr_beat       = '0;
    assign l2_acquire_o.client_xact_id  = 1'b0;

    assign fill_line_valid_o = line_valid_q;
    assign fill_line_o.paddr = line_addr_q;
    assign fill_line_o.data  = beats_q;

    // L2 only grants after an acquire went out
    a_no_idle_grant: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        l2_grant_valid_i |-> state_q != FILL_IDLE
    ) else $error("grant beat with no fill in progress");

endmodule

// File: rtl/mem_tile.sv
/*
 * Memory request fabric top: walker adapter, data cache arbiter and
 * L2 instruction fill adapter
 */
`timescale 1ns/1ps
`include "tile_cfg.svh"

module mem_tile (
    input  logic                     clk_i,
    input  logic                     rst_n_i,

    // Page walker
    input  logic                     ptw_req_valid_i,
    input  dmem_pkg::ptw_req_t       ptw_req_i,
    output logic                     ptw_req_ready_o,
    output dmem_pkg::ptw_resp_t      ptw_resp_o,

    // Core load/store unit
    input  logic                     core_req_valid_i,
    input  dmem_pkg::dmem_req_t      core_req_i,
    output logic                     core_req_ready_o,
    output dmem_pkg::dmem_core_rsp_t core_rsp_o,

    // Data cache port
    output logic                     dcache_req_valid_o,
    output dmem_pkg::dmem_req_t      dcache_req_o,
    input  logic                     dcache_req_ready_i,
    input  logic                     dcache_rsp_valid_i,
    input  dmem_pkg::dmem_rsp_t      dcache_rsp_i,

    // Instruction fill
    input  logic                     fill_req_valid_i,
    input  logic [`TILE_PADDR_W-1:0] fill_paddr_i,
    output logic                     fill_req_ready_o,
    output logic                     fill_line_valid_o,
    output ifill_pkg::fill_line_t    fill_line_o,

    // L2 network
    output logic                     l2_acquire_valid_o,
    output ifill_pkg::l2_acquire_t   l2_acquire_o,
    input  logic                     l2_acquire_ready_i,
    input  logic                     l2_grant_valid_i,
    input  ifill_pkg::l2_grant_t     l2_grant_i
);
    import dmem_pkg::*;

    // Walker adapter to arbiter
    logic                    ptw_dmem_valid;
    dmem_req_t               ptw_dmem_req;
    logic                    ptw_dmem_ready;
    logic                    ptw_rsp_valid;
    logic [`TILE_DATA_W-1:0] ptw_rsp_data;

    ptw_dmem_adapter u_ptw_adapter (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .ptw_req_valid_i (ptw_req_valid_i),
        .ptw_req_i       (ptw_req_i),
        .ptw_req_ready_o (ptw_req_ready_o),
        .ptw_resp_o      (ptw_resp_o),
        .req_valid_o     (ptw_dmem_valid),
        .req_o           (ptw_dmem_req),
        .req_ready_i     (ptw_dmem_ready),
        .rsp_valid_i     (ptw_rsp_valid),
        .rsp_data_i      (ptw_rsp_data)
    );

    dmem_arbiter u_dmem_arb (
        .clk_i              (clk_i),
        .rst_n_i            (rst_n_i),
        .ptw_valid_i        (ptw_dmem_valid),
        .ptw_req_i          (ptw_dmem_req),
        .ptw_ready_o        (ptw_dmem_ready),
        .core_valid_i       (core_req_valid_i),
        .core_req_i         (core_req_i),
        .core_ready_o       (core_req_ready_o),
        .dcache_valid_o     (dcache_req_valid_o),
        .dcache_req_o       (dcache_req_o),
        .dcache_ready_i     (dcache_req_ready_i),
        .dcache_rsp_valid_i (dcache_rsp_valid_i),
        .dcache_rsp_i       (dcache_rsp_i),
        .ptw_rsp_valid_o    (ptw_rsp_valid),
        .ptw_rsp_data_o     (ptw_rsp_data),
        .core_rsp_o         (core_rsp_o)
    );

    l2_fill_adapter u_fill_adapter (
        .clk_i              (clk_i),
        .rst_n_i            (rst_n_i),
        .fill_req_valid_i   (fill_req_valid_i),
        .fill_paddr_i       (fill_paddr_i),
        .fill_req_ready_o   (fill_req_ready_o),
        .l2_acquire_valid_o (l2_acquire_valid_o),
        .l2_acquire_o       (l2_acquire_o),
        .l2_acquire_ready_i (l2_acquire_ready_i),
        .l2_grant_valid_i   (l2_grant_valid_i),
        .l2_grant_i         (l2_grant_i),
        .fill_line_valid_o  (fill_line_valid_o),
        .fill_line_o        (fill_line_o)
    );

endmodule

// File: verification/clk_rst_gen.sv
/*
 * Testbench clock and reset source: 10 ns clock, reset held low
 * for the first four rising edges
 */
`timescale 1ns/1ps

module clk_rst_gen (
    output logic clk_o,
    output logic rst_n_o
);
    initial begin
        clk_o   = 1'b0;
        rst_n_o = 1'b0;
    end

    always #5 clk_o = ~clk_o;

    // Release on the fourth rising edge
    initial begin
        repeat (4) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

// File: verification/tb_mem_tile.sv
/*
 * Testbench for the memory request fabric: random walker, core and
 * fill traffic against data cache and L2 models
 */
`timescale 1ns/1ps
`include "tile_cfg.svh"

module tb_mem_tile;
    import dmem_pkg::*;
    import ifill_pkg::*;

    localparam int N_PTW          = 40;
    localparam int N_CORE         = 60;
    localparam int N_FILL         = 12;
    localparam int LONGEST        = (N_CORE > N_PTW) ? N_CORE : N_PTW;
    localparam int TIMEOUT_CYCLES = 200 * LONGEST;
    localparam logic [`TILE_DATA_W-1:0] RSP_XOR = 64'hA5C3_0F96_5A3C_F069;

    typedef logic [639:0] cmp_t;

    // Response waiting inside the cache model
    typedef struct packed {
        logic [31:0]             due;
        dmem_sid_t               sid;
        logic [`TILE_DATA_W-1:0] rdata;
    } cache_rsp_t;

    logic                     clk_i;
    logic                     rst_n_i;
    logic                     ptw_req_valid_i;
    ptw_req_t                 ptw_req_i;
    logic                     ptw_req_ready_o;
    ptw_resp_t                ptw_resp_o;
    logic                     core_req_valid_i;
    dmem_req_t                core_req_i;
    logic                     core_req_ready_o;
    dmem_core_rsp_t           core_rsp_o;
    logic                     dcache_req_valid_o;
    dmem_req_t                dcache_req_o;
    logic                     dcache_req_ready_i;
    logic                     dcache_rsp_valid_i;
    dmem_rsp_t                dcache_rsp_i;
    logic                     fill_req_valid_i;
    logic [`TILE_PADDR_W-1:0] fill_paddr_i;
    logic                     fill_req_ready_o;
    logic                     fill_line_valid_o;
    fill_line_t               fill_line_o;
    logic                     l2_acquire_valid_o;
    l2_acquire_t              l2_acquire_o;
    logic                     l2_acquire_ready_i;
    logic                     l2_grant_valid_i;
    l2_grant_t                l2_grant_i;

    // Expected traffic per source, in acceptance order
    dmem_req_t               exp_ptw_req[$];
    dmem_req_t               exp_core_req[$];
    logic [`TILE_DATA_W-1:0] exp_ptw_data[$];
    logic [`TILE_DATA_W-1:0] exp_core_data[$];
    cache_rsp_t              pend[$];
    dmem_sid_t               port_sids[$];
    logic [31:0]             cyc;
    logic [31:0]             last_due;
    logic                    walk_busy;
    int                      errors;
    int                      checks;

    clk_rst_gen u_clk_rst (
        .clk_o   (clk_i),
        .rst_n_o (rst_n_i)
    );

    mem_tile dut (.*);

    task automatic check_equal(input string what, input cmp_t got, input cmp_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    //----------------------------------------------------------------------
    // Reference rules and random requests
    //----------------------------------------------------------------------
    function automatic dmem_req_t expect_walk(input ptw_req_t r);
        dmem_req_t e;
        e.addr  = r.addr;
        e.wdata = r.data;
        e.size  = r.size;
        e.sid   = 1'b0;
        if (r.cmd == 5'b01010) begin
            e.op = DMEM_AMO_OR;
            e.be = 8'hFF;
        end else begin
            e.op = DMEM_LOAD;
            e.be = 8'h00;
        end
        return e;
    endfunction

    function automatic ptw_req_t random_walk();
        ptw_req_t r;
        r.cmd = 5'($urandom);
        if ($urandom % 2) begin
            r.cmd = 5'b01010;
        end
        r.addr = 40'({$urandom, $urandom});
        r.data = {$urandom, $urandom};
        r.size = 3'($urandom);
        return r;
    endfunction

    function automatic dmem_req_t random_core();
        dmem_req_t r;
        r.addr  = 40'({$urandom, $urandom});
        r.wdata = {$urandom, $urandom};
        r.op    = ($urandom % 2) ? DMEM_AMO_OR : DMEM_LOAD;
        r.be    = 8'($urandom);
        r.size  = 3'($urandom);
        r.sid   = 1'($urandom);
        return r;
    endfunction

    function automatic logic fabric_idle();
        return exp_ptw_req.size() == 0 && exp_core_req.size() == 0 &&
               exp_ptw_data.size() == 0 && exp_core_data.size() == 0 &&
               pend.size() == 0 && !walk_busy && !dcache_req_valid_o;
    endfunction

    //----------------------------------------------------------------------
    // Drivers, called right after a rising edge
    //----------------------------------------------------------------------
    task automatic send_walk(input ptw_req_t r);
        ptw_req_valid_i <= 1'b1;
        ptw_req_i       <= r;
        do begin
            @(posedge clk_i);
        end while (!ptw_req_ready_o);
        ptw_req_valid_i <= 1'b0;
    endtask

    task automatic send_core(input dmem_req_t r);
        core_req_valid_i <= 1'b1;
        core_req_i       <= r;
        do begin
            @(posedge clk_i);
        end while (!core_req_ready_o);
        core_req_valid_i <= 1'b0;
    endtask

    task automatic run_walks(input int n);
        repeat (n) begin
            repeat ($urandom % 4) @(posedge clk_i);
            send_walk(random_walk());
        end
    endtask

    task automatic run_cores(input int n);
        repeat (n) begin
            repeat ($urandom % 3) @(posedge clk_i);
            send_core(random_core());
        end
    endtask

    // Fill requests with the L2 side played inline
    task automatic run_fills(input int n);
        l2_acquire_t exp_acq;
        fill_line_t  exp_line;
        logic        acq_done;
        repeat (n) begin
            repeat ($urandom % 4) @(posedge clk_i);
            exp_line.paddr = 40'({$urandom, $urandom});
            for (int b = 0; b < `TILE_FILL_BEATS; b++) begin
                exp_line.data[b] = {$urandom, $urandom, $urandom, $urandom};
            end
            fill_req_valid_i <= 1'b1;
            fill_paddr_i     <= exp_line.paddr;
            do begin
                @(posedge clk_i);
            end while (!fill_req_ready_o);
            fill_req_valid_i <= 1'b0;

            exp_acq.addr_block      = exp_line.paddr;
            exp_acq.a_type          = `TILE_ACQ_A_TYPE;
            exp_acq.union_bits      = `TILE_ACQ_UNION;
            exp_acq.is_builtin_type = 1'b1;
            exp_acq.addr_beat       = '0;
            exp_acq.client_xact_id  = 1'b0;
            acq_done = 1'b0;
            while (!acq_done) begin
                l2_acquire_ready_i <= ($urandom % 3) == 0;
                @(posedge clk_i);
                check_equal("fill ready during acquire", cmp_t'(fill_req_ready_o), 0);
                if (l2_acquire_valid_o && l2_acquire_ready_i) begin
                    check_equal("acquire fields", cmp_t'(l2_acquire_o), cmp_t'(exp_acq));
                    acq_done = 1'b1;
                end
            end
            l2_acquire_ready_i <= 1'b0;

            for (int b = 0; b < `TILE_FILL_BEATS; b++) begin
                repeat ($urandom % 3) begin
                    l2_grant_valid_i <= 1'b0;
                    @(posedge clk_i);
                end
                l2_grant_valid_i     <= 1'b1;
                l2_grant_i.addr_beat <= 2'(b);
                l2_grant_i.data      <= exp_line.data[b];
                @(posedge clk_i);
                check_equal("single acquire per fill", cmp_t'(l2_acquire_valid_o), 0);
                check_equal("fill ready during beats", cmp_t'(fill_req_ready_o), 0);
            end
            l2_grant_valid_i <= 1'b0;

            // Line pulse follows the last beat by one cycle
            @(posedge clk_i);
            check_equal("fill line valid", cmp_t'(fill_line_valid_o), 1);
            check_equal("fill line", cmp_t'(fill_line_o), cmp_t'(exp_line));
            check_equal("fill ready after line", cmp_t'(fill_req_ready_o), 1);
        end
    endtask

    task automatic wait_idle();
        do begin
            @(posedge clk_i);
        end while (!fabric_idle());
    endtask

    // Walker and core offered together, walker must reach the cache first
    task automatic race_test();
        int idx;
        idx = port_sids.size();
        fork
            send_walk(random_walk());
            send_core(random_core());
        join
        while (port_sids.size() < idx + 2) begin
            @(posedge clk_i);
        end
        check_equal("first sid after joint offer", cmp_t'(port_sids[idx]), 0);
        check_equal("second sid after joint offer", cmp_t'(port_sids[idx + 1]), 1);
    endtask

    //----------------------------------------------------------------------
    // Source side monitor and response checks
    //----------------------------------------------------------------------
    always @(posedge clk_i) begin
        if (rst_n_i) begin
            if (walk_busy) begin
                check_equal("walker ready while walk outstanding", cmp_t'(ptw_req_ready_o), 0);
            end
            check_equal("response routing", cmp_t'({ptw_resp_o.valid, core_rsp_o.valid}),
                        dcache_rsp_valid_i ? (dcache_rsp_i.sid ? 1 : 2) : 0);
            if (ptw_resp_o.valid) begin
                if (exp_ptw_data.size() == 0) begin
                    report_error("walker response with no walk expected");
                end else begin
                    check_equal("walker data", cmp_t'(ptw_resp_o.data),
                                cmp_t'(exp_ptw_data.pop_front()));
                end
                walk_busy = 1'b0;
            end
            if (core_rsp_o.valid) begin
                if (exp_core_data.size() == 0) begin
                    report_error("core response with no request expected");
                end else begin
                    check_equal("core data", cmp_t'(core_rsp_o.rdata),
                                cmp_t'(exp_core_data.pop_front()));
                end
            end
            if (ptw_req_valid_i && ptw_req_ready_o) begin
                exp_ptw_req.push_back(expect_walk(ptw_req_i));
                exp_ptw_data.push_back(64'(ptw_req_i.addr) ^ RSP_XOR);
                walk_busy = 1'b1;
            end
            if (core_req_valid_i && core_req_ready_o) begin
                exp_core_req.push_back({core_req_i[$bits(dmem_req_t)-1:1], 1'b1});
                exp_core_data.push_back(64'(core_req_i.addr) ^ RSP_XOR);
            end
        end
    end

    //----------------------------------------------------------------------
    // Data cache model, in-order answers 1 to 4 cycles after acceptance
    //----------------------------------------------------------------------
    always @(posedge clk_i) begin
        cache_rsp_t r;
        if (!rst_n_i) begin
            dcache_req_ready_i <= 1'b0;
            dcache_rsp_valid_i <= 1'b0;
        end else begin
            cyc = cyc + 1;
            dcache_req_ready_i <= ($urandom % 4) != 0;
            if (pend.size() != 0 && pend[0].due <= cyc) begin
                r = pend.pop_front();
                dcache_rsp_valid_i <= 1'b1;
                dcache_rsp_i.sid   <= r.sid;
                dcache_rsp_i.rdata <= r.rdata;
            end else begin
                dcache_rsp_valid_i <= 1'b0;
            end
            if (dcache_req_valid_o && dcache_req_ready_i) begin
                port_sids.push_back(dcache_req_o.sid);
                if (dcache_req_o.sid == 1'b0 && exp_ptw_req.size() != 0) begin
                    check_equal("walker request on cache port", cmp_t'(dcache_req_o),
                                cmp_t'(exp_ptw_req.pop_front()));
                end else if (dcache_req_o.sid == 1'b1 && exp_core_req.size() != 0) begin
                    check_equal("core request on cache port", cmp_t'(dcache_req_o),
                                cmp_t'(exp_core_req.pop_front()));
                end else begin
                    report_error("cache request that no source sent");
                end
                r.due = cyc + 1 + ($urandom % 4);
                if (r.due <= last_due) begin
                    r.due = last_due + 1;
                end
                last_due = r.due;
                r.sid    = dcache_req_o.sid;
                r.rdata  = 64'(dcache_req_o.addr) ^ RSP_XOR;
                pend.push_back(r);
            end
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * 10);
        report_error($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
        finish_run();
    end

    initial begin
        ptw_req_valid_i    = 1'b0;
        ptw_req_i          = '0;
        core_req_valid_i   = 1'b0;
        core_req_i         = '0;
        dcache_req_ready_i = 1'b0;
        dcache_rsp_valid_i = 1'b0;
        dcache_rsp_i       = '0;
        fill_req_valid_i   = 1'b0;
        fill_paddr_i       = '0;
        l2_acquire_ready_i = 1'b0;
        l2_grant_valid_i   = 1'b0;
        l2_grant_i         = '0;
        walk_busy          = 1'b0;
        cyc                = '0;
        last_due           = '0;
        errors             = 0;
        checks             = 0;
        void'($urandom(53131));

        wait (rst_n_i === 1'b1);
        @(posedge clk_i);
        // Valids low and readies high straight out of reset
        check_equal("state after reset", cmp_t'({dcache_req_valid_o, l2_acquire_valid_o,
                    fill_line_valid_o, ptw_resp_o.valid, core_rsp_o.valid, ptw_req_ready_o,
                    core_req_ready_o, fill_req_ready_o}), 7);

        fork
            run_walks(N_PTW);
            run_cores(N_CORE);
            run_fills(N_FILL);
        join
        wait_idle();
        race_test();
        wait_idle();
        finish_run();
    end

endmodule

// File: src.f
+incdir+common
common/dmem_pkg.sv
common/ifill_pkg.sv
dmem_port/ptw_dmem_adapter.sv
dmem_port/dmem_arbiter.sv
ifill/l2_fill_adapter.sv
rtl/mem_tile.sv
verification/clk_rst_gen.sv
verification/tb_mem_tile.sv
